// File: logic/reg_wr_defines.svh
// sizing macros for the register-file write path
// client count, register count, register width
`ifndef REG_WR_DEFINES_SVH
`define REG_WR_DEFINES_SVH

// number of write clients competing for the slot
// alu, load unit, multiply unit
`define NUM_CLIENTS 3

// registers in the file
// select width is derived from this in the package
`define REG_COUNT 16

// bits per register
`define DATA_WIDTH 32

// client index and select widths follow from
// the two counts above, see reg_wr_pkg
// keep NUM_CLIENTS at 4 or below while
// client_id_t stays 2 bits wide

`endif

// File: logic/reg_wr_pkg.sv
// shared types of the register-file write path
// register select, register data, client index
// and the write command to the register file
`default_nettype none

`include "reg_wr_defines.svh"

package reg_wr_pkg;

    // derived widths
    localparam int REG_SEL_WIDTH = $clog2(`REG_COUNT);
    localparam int CLIENT_ID_WIDTH = 2;

    // register index, 4 bits for 16 entries
    typedef logic [REG_SEL_WIDTH-1:0] reg_sel_t;

    // register contents
    typedef logic [`DATA_WIDTH-1:0] reg_data_t;

    // which client owns a grant
    typedef logic [CLIENT_ID_WIDTH-1:0] client_id_t;

    // one write into the register file, 37 bits
    typedef struct packed {
        logic      valid;
        reg_sel_t  reg_sel;
        reg_data_t data;
    } wr_cmd_t;

endpackage

`default_nettype wire

// File: logic/reg_wr_if.sv
// request channel of one write client
// modport client for the requester side
// modport arbiter for the granting side
`default_nettype none

interface reg_wr_if;
    import reg_wr_pkg::*;

    // target register and payload
    // payload only needed with req, or in the cycle after a resv ack
    reg_sel_t  reg_sel;
    reg_data_t data;

    // immediate write request
    logic req;
    // reservation for the next write slot
    // wins over req when both are high
    logic resv;

    // one-cycle grant pulse from the arbiter
    logic ack;

    modport client (
        output reg_sel,
        output data,
        output req,
        output resv,
        input  ack
    );

    modport arbiter (
        input  reg_sel,
        input  data,
        input  req,
        input  resv,
        output ack
    );

endinterface

`default_nettype wire

// File: logic/reg_wr_arbiter.sv
// write-slot arbiter for the register file
// reservations first, then lowest-index immediate request
// registered ack pulses and registered write command
`default_nettype none

`include "reg_wr_defines.svh"

module reg_wr_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    reg_wr_if.arbiter          clients [`NUM_CLIENTS],
    output reg_wr_pkg::wr_cmd_t wr_cmd
);
    import reg_wr_pkg::*;

    localparam int NC = `NUM_CLIENTS;

    // flattened client channels
    reg_sel_t  sel_arr  [NC];
    reg_data_t data_arr [NC];
    logic [NC-1:0] req_vec;
    logic [NC-1:0] resv_vec;

    // reservation accepted at the last edge, owns this slot
    logic       resv_pend;
    client_id_t resv_id;

    // arbitration results for the current edge
    logic [NC-1:0] busy_mask;
    logic [NC-1:0] req_elig;
    logic [NC-1:0] resv_elig;
    logic          imm_valid;
    logic          resv_valid;
    client_id_t    imm_id;
    client_id_t    resv_win_id;
    client_id_t    win_id;
    logic [NC-1:0] ack_next;

    // registered outputs
    logic [NC-1:0] ack_q;
    logic          cmd_valid_q;
    reg_sel_t      cmd_sel_q;
    reg_data_t     cmd_data_q;

    // lowest set bit wins
    function automatic client_id_t lowest_set(input logic [NC-1:0] vec);
        client_id_t idx;
        idx = '0;
        for (int i = NC - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = client_id_t'(i);
            end
        end
        return idx;
    endfunction

    for (genvar g = 0; g < NC; g++) begin : g_client
        assign sel_arr[g]  = clients[g].reg_sel;
        assign data_arr[g] = clients[g].data;
        assign req_vec[g]  = clients[g].req;
        assign resv_vec[g] = clients[g].resv;
        assign clients[g].ack = ack_q[g];
    end

    always_comb begin
        // client delivering reserved data ignores its req and resv
        busy_mask = '0;
        if (resv_pend) begin
            busy_mask[resv_id] = 1'b1;
        end
        // req is dropped when resv is also up
        req_elig  = req_vec & ~resv_vec & ~busy_mask;
        resv_elig = resv_vec & ~busy_mask;

        imm_id      = lowest_set(req_elig);
        resv_win_id = lowest_set(resv_elig);

        // reserved slot blocks every immediate request
        imm_valid  = !resv_pend && (|req_elig);
        // only one reservation can target the next slot
        resv_valid = |resv_elig;

        // slot owner for the payload mux
        win_id = resv_pend ? resv_id : imm_id;

        ack_next = '0;
        if (imm_valid) begin
            ack_next[imm_id] = 1'b1;
        end
        if (resv_valid) begin
            ack_next[resv_win_id] = 1'b1;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q       <= '0;
            cmd_valid_q <= 1'b0;
            resv_pend   <= 1'b0;
        end else begin
            ack_q       <= ack_next;
            cmd_valid_q <= resv_pend | imm_valid;
            resv_pend   <= resv_valid;
        end
    end

    // payload capture, only when a slot is used
    always_ff @(posedge clk) begin
        if (resv_pend || imm_valid) begin
            cmd_sel_q  <= sel_arr[win_id];
            cmd_data_q <= data_arr[win_id];
        end
        if (resv_valid) begin
            resv_id <= resv_win_id;
        end
    end

    assign wr_cmd.valid   = cmd_valid_q;
    assign wr_cmd.reg_sel = cmd_sel_q;
    assign wr_cmd.data    = cmd_data_q;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
// register storage of the core
// one write port fed by the arbiter's write command
// two combinational read ports, no write-to-read bypass
`default_nettype none

`include "reg_wr_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    // write command, registered in the arbiter
    input  reg_wr_pkg::wr_cmd_t   wr_cmd,
    // read port a
    input  reg_wr_pkg::reg_sel_t  rd_sel_a,
    output reg_wr_pkg::reg_data_t rd_data_a,
    // read port b
    input  reg_wr_pkg::reg_sel_t  rd_sel_b,
    output reg_wr_pkg::reg_data_t rd_data_b
);
    import reg_wr_pkg::*;

    localparam int RC = `REG_COUNT;

    // the registers themselves
    reg_data_t regs [RC];

    // write enable per entry, decoded from the command
    logic [RC-1:0] wr_en;

    always_comb begin
        wr_en = '0;
        if (wr_cmd.valid) begin
            wr_en[wr_cmd.reg_sel] = 1'b1;
        end
    end

    // every entry clears at reset
    // register 0 has no special meaning
    for (genvar r = 0; r < RC; r++) begin : g_reg
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                regs[r] <= '0;
            end else if (wr_en[r]) begin
                regs[r] <= wr_cmd.data;
            end
        end
    end

    // plain selects
    // new value shows one edge after the command
    assign rd_data_a = regs[rd_sel_a];
    assign rd_data_b = regs[rd_sel_b];

endmodule

`default_nettype wire

// File: logic/reg_wr_top.sv
// top level of the register-file write path
// plain packed client ports mapped onto one channel per client
// arbiter and register file instances
`default_nettype none

`include "reg_wr_defines.svh"

module reg_wr_top (
    input  logic                                      clk,
    input  logic                                      rst_n,

    // client channels, packed with client 0 in the low slice
    input  reg_wr_pkg::reg_sel_t  [`NUM_CLIENTS-1:0]  reg_sel,
    input  reg_wr_pkg::reg_data_t [`NUM_CLIENTS-1:0]  data,
    input  logic                  [`NUM_CLIENTS-1:0]  req,
    input  logic                  [`NUM_CLIENTS-1:0]  resv,
    output logic                  [`NUM_CLIENTS-1:0]  ack,

    // read ports
    input  reg_wr_pkg::reg_sel_t                      rd_sel_a,
    output reg_wr_pkg::reg_data_t                     rd_data_a,
    input  reg_wr_pkg::reg_sel_t                      rd_sel_b,
    output reg_wr_pkg::reg_data_t                     rd_data_b
);
    import reg_wr_pkg::*;

    // one request channel per client
    reg_wr_if client_if [`NUM_CLIENTS] ();

    // arbiter to register file
    wr_cmd_t wr_cmd;

    // map plain ports onto the channels
    for (genvar g = 0; g < `NUM_CLIENTS; g++) begin : g_map
        assign client_if[g].reg_sel = reg_sel[g];
        assign client_if[g].data    = data[g];
        assign client_if[g].req     = req[g];
        assign client_if[g].resv    = resv[g];
        // grant back out
        assign ack[g] = client_if[g].ack;
    end

    // slot arbitration
    // reserved client first, else lowest index with req
    reg_wr_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .clients (client_if),
        .wr_cmd  (wr_cmd)
    );

    // storage
    // req to read-visible is 2 edges, resv to read-visible is 3
    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_cmd    (wr_cmd),
        .rd_sel_a  (rd_sel_a),
        .rd_data_a (rd_data_a),
        .rd_sel_b  (rd_sel_b),
        .rd_data_b (rd_data_b)
    );

endmodule

`default_nettype wire

// File: verif/reg_wr_tb.sv
// directed testbench for the register-file write path
// reference register model updated on every ack
// compare task, per-test result lines, cycle-count timeout
`default_nettype none

`include "reg_wr_defines.svh"

module reg_wr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import reg_wr_pkg::*;

    localparam int NC = `NUM_CLIENTS;
    localparam int RC = `REG_COUNT;
    // tests need a few hundred cycles, limit is about four times that
    localparam int MAX_CYCLES = 2000;
    localparam int RANDOM_WRITES = 40;

    logic clk;
    logic rst_n;
    reg_sel_t  [NC-1:0] reg_sel;
    reg_data_t [NC-1:0] data;
    logic      [NC-1:0] req;
    logic      [NC-1:0] resv;
    logic      [NC-1:0] ack;
    reg_sel_t  rd_sel_a;
    reg_data_t rd_data_a;
    reg_sel_t  rd_sel_b;
    reg_data_t rd_data_b;

    // expected register contents
    reg_data_t model [RC];
    // cycle in which each client last saw its ack
    int ack_cycle [NC];

    int cycle_cnt = 0;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    integer seed;

    reg_wr_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_sel   (reg_sel),
        .data      (data),
        .req       (req),
        .resv      (resv),
        .ack       (ack),
        .rd_sel_a  (rd_sel_a),
        .rd_data_a (rd_data_a),
        .rd_sel_b  (rd_sel_b),
        .rd_data_b (rd_data_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: no end of tests after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // 1 ns after the next rising edge, where inputs change
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [`DATA_WIDTH-1:0] exp,
                               input logic [`DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (err_cnt == err0) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAIL, %0d errors", name, err_cnt - err0);
        end
    endtask

    // port a walks up, port b walks down
    task automatic check_all_regs();
        for (int r = 0; r < RC; r++) begin
            next_cycle();
            rd_sel_a = reg_sel_t'(r);
            rd_sel_b = reg_sel_t'(RC - 1 - r);
            #1;
            check_value($sformatf("rd_data_a[%0d]", r), model[r], rd_data_a);
            check_value($sformatf("rd_data_b[%0d]", RC - 1 - r), model[RC - 1 - r],
                        rd_data_b);
        end
    endtask

    // one client write, either kind, held until acked
    // starts and ends 1 ns after an edge
    task automatic do_write(input int c, input bit kind_resv, input reg_sel_t sel,
                            input reg_data_t val);
        bit got;
        got = 1'b0;
        if (kind_resv) begin
            resv[c] = 1'b1;
        end else begin
            req[c]     = 1'b1;
            reg_sel[c] = sel;
            data[c]    = val;
        end
        while (!got) begin
            next_cycle();
            got = ack[c];
        end
        ack_cycle[c] = cycle_cnt;
        if (kind_resv) begin
            // payload goes out in the cycle after the ack
            resv[c]    = 1'b0;
            reg_sel[c] = sel;
            data[c]    = val;
            next_cycle();
            check_value($sformatf("ack[%0d] in data cycle", c), '0, ack[c]);
        end else begin
            req[c] = 1'b0;
        end
        reg_sel[c] = '0;
        data[c]    = '0;
        // reserved slots land after any immediate acked at the same edge
        model[sel] = val;
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = err_cnt;
        check_value("ack", '0, ack);
        check_all_regs();
        report_test("reset state", err0);
    endtask

    task automatic test_single_req();
        int err0;
        reg_data_t val;
        err0 = err_cnt;
        val = $random(seed);
        next_cycle();
        req[1]     = 1'b1;
        reg_sel[1] = 4'd5;
        data[1]    = val;
        rd_sel_a   = 4'd5;
        // req sampled at this edge
        next_cycle();
        check_value("ack[1]", 1, ack[1]);
        check_value("rd_data_a[5] before write", model[5], rd_data_a);
        req[1]     = 1'b0;
        reg_sel[1] = '0;
        data[1]    = '0;
        model[5]   = val;
        next_cycle();
        check_value("ack[1] after pulse", 0, ack[1]);
        check_value("rd_data_a[5]", val, rd_data_a);
        report_test("single immediate request", err0);
    endtask

    task automatic test_three_reqs();
        int err0;
        int start;
        reg_data_t val [NC];
        err0 = err_cnt;
        for (int c = 0; c < NC; c++) begin
            val[c] = $random(seed);
        end
        next_cycle();
        start = cycle_cnt;
        for (int c = 0; c < NC; c++) begin
            automatic int cc = c;
            fork
                do_write(cc, 1'b0, reg_sel_t'(10 + cc), val[cc]);
            join_none
        end
        wait fork;
        // one grant per cycle, lowest index first
        for (int c = 0; c < NC; c++) begin
            check_value($sformatf("ack cycle of client %0d", c), start + 1 + c,
                        ack_cycle[c]);
        end
        check_all_regs();
        report_test("three simultaneous requests", err0);
    endtask

    task automatic test_reservation();
        int err0;
        reg_data_t val;
        reg_data_t old;
        err0 = err_cnt;
        val = $random(seed);
        old = model[9];
        next_cycle();
        resv[2]  = 1'b1;
        rd_sel_a = 4'd9;
        next_cycle();
        check_value("ack[2]", 1, ack[2]);
        // resv left up in the data cycle, arbiter must ignore it
        reg_sel[2] = 4'd9;
        data[2]    = val;
        // payload captured at this edge
        next_cycle();
        check_value("ack[2] in data cycle", 0, ack[2]);
        check_value("rd_data_a[9] before write", old, rd_data_a);
        resv[2]    = 1'b0;
        reg_sel[2] = '0;
        data[2]    = '0;
        next_cycle();
        model[9] = val;
        check_value("rd_data_a[9]", val, rd_data_a);
        report_test("reservation", err0);
    endtask

    task automatic test_resv_blocks_req();
        int err0;
        reg_data_t d0;
        reg_data_t d1;
        err0 = err_cnt;
        d0 = $random(seed);
        d1 = $random(seed);
        next_cycle();
        resv[0]  = 1'b1;
        rd_sel_a = 4'd3;
        next_cycle();
        check_value("ack[0]", 1, ack[0]);
        resv[0]    = 1'b0;
        reg_sel[0] = 4'd3;
        data[0]    = d0;
        // client 1 aims at the reserved slot, same register
        req[1]     = 1'b1;
        reg_sel[1] = 4'd3;
        data[1]    = d1;
        next_cycle();
        check_value("ack[1] in reserved slot", 0, ack[1]);
        reg_sel[0] = '0;
        data[0]    = '0;
        model[3]   = d0;
        next_cycle();
        check_value("ack[1] after reserved slot", 1, ack[1]);
        check_value("rd_data_a[3] reserved write", d0, rd_data_a);
        req[1]     = 1'b0;
        reg_sel[1] = '0;
        data[1]    = '0;
        next_cycle();
        model[3] = d1;
        check_value("rd_data_a[3] later write", d1, rd_data_a);
        report_test("reservation blocks request", err0);
    endtask

    task automatic test_random_traffic();
        int err0;
        int done;
        logic [31:0] rnd;
        bit        en   [NC];
        bit        kind [NC];
        reg_sel_t  sel  [NC];
        reg_data_t val  [NC];
        err0 = err_cnt;
        done = 0;
        next_cycle();
        // rounds of up to one write per client, all started together
        while (done < RANDOM_WRITES) begin
            for (int c = 0; c < NC; c++) begin
                en[c] = (done < RANDOM_WRITES);
                if (en[c]) begin
                    done++;
                end
                rnd = $random(seed);
                kind[c] = rnd[0];
                sel[c]  = rnd[4:1];
                val[c]  = $random(seed);
            end
            for (int c = 0; c < NC; c++) begin
                automatic int cc = c;
                fork
                    if (en[cc]) begin
                        do_write(cc, kind[cc], sel[cc], val[cc]);
                    end
                join_none
            end
            wait fork;
        end
        check_all_regs();
        report_test("random mixed traffic", err0);
    endtask

    initial begin
        seed     = 7;
        rst_n    = 1'b0;
        reg_sel  = '0;
        data     = '0;
        req      = '0;
        resv     = '0;
        rd_sel_a = '0;
        rd_sel_b = '0;
        for (int r = 0; r < RC; r++) begin
            model[r] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_single_req();
        test_three_reqs();
        test_reservation();
        test_resv_blocks_req();
        test_random_traffic();

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: reg_wr_top.f
+incdir+logic
logic/reg_wr_pkg.sv
logic/reg_wr_if.sv
logic/reg_wr_arbiter.sv
logic/reg_file.sv
logic/reg_wr_top.sv
verif/reg_wr_tb.sv
